// ==== logic/tx_config.svh ====
// Frame timing and payload length limits for the Ethernet transmit test block
// Included by the RTL and testbench files that need these values
`ifndef TX_CONFIG_SVH
`define TX_CONFIG_SVH

// Count of 0x55 bytes ahead of the SFD
`define TX_PREAMBLE_LEN 7

// Idle cycles after the last FCS byte before busy drops
`define TX_IPG_LEN 12

// Payload length field width, enough for 1500
`define TX_LEN_W 11

// Legal payload range, no padding is done
`define TX_MIN_LEN 46
`define TX_MAX_LEN 1500

`endif

// ==== logic/tx_pkg.sv ====
// Shared types for the Ethernet transmit test block
// Referenced by scoped name from the sequencer, CRC and output mux
package tx_pkg;

	// Frame phases in the order they are sent
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		PREAMBLE = 3'd1,
		SFD      = 3'd2,
		PAYLOAD  = 3'd3,
		FCS      = 3'd4,
		GAP      = 3'd5
	} tx_phase_e;

	// One CRC word, seen whole for the update
	// or as bytes for the FCS, byte 0 goes out first
	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} crc_word_u;

endpackage

// ==== logic/frame_sequencer.sv ====
// Frame phase FSM for the transmit test block
// Steps through preamble, SFD, payload, FCS and gap on each accepted start
`timescale 1ns/1ps
`include "tx_config.svh"

module frame_sequencer (
	input  logic                    tx_clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic [`TX_LEN_W-1:0]    payload_len,
	input  logic [7:0]              pattern_base,
	output logic                    busy,
	output tx_pkg::tx_phase_e       phase,
	output logic [7:0]              seq_byte,
	output logic [`TX_LEN_W-1:0]    seq_index
);

	// Last index of the fixed-length phases
	localparam logic [`TX_LEN_W-1:0] PRE_LAST = `TX_PREAMBLE_LEN - 1;
	localparam logic [`TX_LEN_W-1:0] FCS_LAST = 3;
	localparam logic [`TX_LEN_W-1:0] IPG_LAST = `TX_IPG_LEN - 1;
	localparam logic [`TX_LEN_W-1:0] LEN_ONE  = 1;

	// Frame parameters held for the whole frame
	logic [`TX_LEN_W-1:0] len_q;
	logic [7:0]           base_q;

	logic [`TX_LEN_W-1:0] last_index;
	logic                 phase_end;
	logic                 accept;

	// Start only counts when no frame is in flight
	assign accept = start && !busy;

	// Busy covers everything but IDLE, gap included
	assign busy = (phase != tx_pkg::IDLE);

	// Incrementing pattern, wraps at 256
	assign seq_byte = base_q + seq_index[7:0];

	// Where the byte counter stops in each phase
	always_comb begin
		case (phase)
			tx_pkg::PREAMBLE: last_index = PRE_LAST;
			tx_pkg::PAYLOAD:  last_index = len_q - LEN_ONE;
			tx_pkg::FCS:      last_index = FCS_LAST;
			tx_pkg::GAP:      last_index = IPG_LAST;
			default:          last_index = '0;
		endcase
	end

	assign phase_end = (seq_index == last_index);

	// Length and pattern sampled at the accepting edge
	always_ff @(posedge tx_clk) begin
		if (accept) begin
			len_q  <= payload_len;
			base_q <= pattern_base;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			phase     <= tx_pkg::IDLE;
			seq_index <= '0;
		end else if (phase == tx_pkg::IDLE) begin
			// Preamble starts on the same edge as busy
			seq_index <= '0;
			if (accept) begin
				phase <= tx_pkg::PREAMBLE;
			end
		end else if (phase_end) begin
			// Counter restarts for every phase
			seq_index <= '0;
			case (phase)
				tx_pkg::PREAMBLE: phase <= tx_pkg::SFD;
				tx_pkg::SFD:      phase <= tx_pkg::PAYLOAD;
				tx_pkg::PAYLOAD:  phase <= tx_pkg::FCS;
				tx_pkg::FCS:      phase <= tx_pkg::GAP;
				default:          phase <= tx_pkg::IDLE;
			endcase
		end else begin
			seq_index <= seq_index + LEN_ONE;
		end
	end

endmodule

// ==== logic/fcs_crc32.sv ====
// Running Ethernet CRC-32 over the payload bytes of one frame
// Reseeded in the SFD cycle, output is already inverted for the FCS
`timescale 1ns/1ps

module fcs_crc32 (
	input  logic              tx_clk,
	input  logic              rst_n,
	input  tx_pkg::tx_phase_e phase,
	input  logic [7:0]        seq_byte,
	output tx_pkg::crc_word_u crc
);

	// Reflected form of 0x04C11DB7
	localparam logic [31:0] POLY_REFL = 32'hEDB88320;

	tx_pkg::crc_word_u crc_q;

	// One byte through the LSB-first shift register
	function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] d);
		logic [31:0] c;
		c = c_in ^ {24'h0, d};
		for (int i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ POLY_REFL;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			crc_q.word <= '1;
		end else if (phase == tx_pkg::SFD) begin
			// Seed just ahead of the first payload byte
			crc_q.word <= '1;
		end else if (phase == tx_pkg::PAYLOAD) begin
			crc_q.word <= crc_byte(crc_q.word, seq_byte);
		end
	end

	// Final inversion, byte order already matches the wire
	assign crc.word = ~crc_q.word;

endmodule

// ==== logic/gmii_tx_mux.sv ====
// GMII output stage for the transmit test block
// Picks the byte for the current phase and registers txd and tx_en
`timescale 1ns/1ps
`include "tx_config.svh"

module gmii_tx_mux (
	input  logic                 tx_clk,
	input  logic                 rst_n,
	input  tx_pkg::tx_phase_e    phase,
	input  logic [7:0]           seq_byte,
	input  logic [`TX_LEN_W-1:0] seq_index,
	input  tx_pkg::crc_word_u    crc,
	output logic [7:0]           gmii_txd,
	output logic                 gmii_tx_en
);

	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hD5;

	logic [7:0] txd_next;
	logic       en_next;

	always_comb begin
		case (phase)
			tx_pkg::PREAMBLE: txd_next = PREAMBLE_BYTE;
			tx_pkg::SFD:      txd_next = SFD_BYTE;
			tx_pkg::PAYLOAD:  txd_next = seq_byte;
			// FCS least significant byte first
			tx_pkg::FCS:      txd_next = crc.bytes[seq_index[1:0]];
			default:          txd_next = 8'h00;
		endcase
	end

	// Enable spans preamble through the last FCS byte
	assign en_next = (phase == tx_pkg::PREAMBLE) || (phase == tx_pkg::SFD) ||
		(phase == tx_pkg::PAYLOAD) || (phase == tx_pkg::FCS);

	// One register stage to the PHY
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			gmii_txd   <= 8'h00;
			gmii_tx_en <= 1'b0;
		end else begin
			gmii_txd   <= txd_next;
			gmii_tx_en <= en_next;
		end
	end

endmodule

// ==== logic/frame_tx_top.sv ====
// Top level of the Ethernet transmit test block
// One test frame on gmii_txd for every start pulse taken while idle
`timescale 1ns/1ps
`include "tx_config.svh"

module frame_tx_top (
	input  logic                 tx_clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic [`TX_LEN_W-1:0] payload_len,
	input  logic [7:0]           pattern_base,
	output logic [7:0]           gmii_txd,
	output logic                 gmii_tx_en,
	output logic                 busy
);

	tx_pkg::tx_phase_e    phase;
	logic [7:0]           seq_byte;
	logic [`TX_LEN_W-1:0] seq_index;
	tx_pkg::crc_word_u    crc;

	// Phase control and payload pattern
	frame_sequencer u_seq (
		.tx_clk       (tx_clk),
		.rst_n        (rst_n),
		.start        (start),
		.payload_len  (payload_len),
		.pattern_base (pattern_base),
		.busy         (busy),
		.phase        (phase),
		.seq_byte     (seq_byte),
		.seq_index    (seq_index)
	);

	// Checksum runs alongside the payload
	fcs_crc32 u_crc (
		.tx_clk   (tx_clk),
		.rst_n    (rst_n),
		.phase    (phase),
		.seq_byte (seq_byte),
		.crc      (crc)
	);

	gmii_tx_mux u_mux (
		.tx_clk     (tx_clk),
		.rst_n      (rst_n),
		.phase      (phase),
		.seq_byte   (seq_byte),
		.seq_index  (seq_index),
		.crc        (crc),
		.gmii_txd   (gmii_txd),
		.gmii_tx_en (gmii_tx_en)
	);

endmodule

// ==== sim/frame_tx_assertions.sv ====
// Concurrent checks on the ports of the transmit test block
// Bound into frame_tx_top by the bind at the end of this file
`timescale 1ns/1ps
`include "tx_config.svh"

module frame_tx_assertions (
	input logic tx_clk,
	input logic rst_n,
	input logic start,
	input logic gmii_tx_en,
	input logic busy
);

	// Saturating count of cycles since gmii_tx_en went low
	logic [4:0] low_cnt;

	// Failure count read by the testbench at the end
	int fail_count = 0;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			low_cnt <= '1;
		end else if (gmii_tx_en) begin
			low_cnt <= '0;
		end else if (low_cnt != '1) begin
			low_cnt <= low_cnt + 5'd1;
		end
	end

	// Sequencer takes start and the mux registers one edge later
	a_en_after_start: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$rose(gmii_tx_en) |-> $past(start && !busy, 2))
		else begin
			fail_count++;
			$error("gmii_tx_en rose without an accepted start two edges before");
		end

	// First gap cycle hides behind the last FCS byte in the output register
	a_busy_in_gap: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(!gmii_tx_en && low_cnt < `TX_IPG_LEN - 1) |-> busy)
		else begin
			fail_count++;
			$error("busy fell before the inter-packet gap was over");
		end

	a_quiet_in_reset: assert property (@(posedge tx_clk)
		!rst_n |=> !gmii_tx_en)
		else begin
			fail_count++;
			$error("gmii_tx_en high while in reset");
		end

endmodule

bind frame_tx_top frame_tx_assertions u_assertions (
	.tx_clk     (tx_clk),
	.rst_n      (rst_n),
	.start      (start),
	.gmii_tx_en (gmii_tx_en),
	.busy       (busy)
);

// ==== sim/frame_tx_tb.sv ====
// Table-driven testbench for the Ethernet transmit test block
// Sends one frame per table row and compares it with a reference frame model
`timescale 1ns/1ps
`include "tx_config.svh"

module frame_tx_tb;

	localparam int N_ROWS      = 8;
	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	// Quiet cycles watched once busy is low
	localparam int TAIL_CYCLES = 4;

	logic                 tx_clk;
	logic                 rst_n;
	logic                 start;
	logic [`TX_LEN_W-1:0] payload_len;
	logic [7:0]           pattern_base;
	logic [7:0]           gmii_txd;
	logic                 gmii_tx_en;
	logic                 busy;

	// Stimulus table with one frame per row
	string      row_name  [N_ROWS];
	int         row_len   [N_ROWS];
	logic [7:0] row_base  [N_ROWS];
	bit         row_extra [N_ROWS];

	int seed         = 28048;
	int clk_cycles   = 0;
	int cycle_limit  = 0;
	int row_errors   = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	frame_tx_top uut (
		.tx_clk       (tx_clk),
		.rst_n        (rst_n),
		.start        (start),
		.payload_len  (payload_len),
		.pattern_base (pattern_base),
		.gmii_txd     (gmii_txd),
		.gmii_tx_en   (gmii_tx_en),
		.busy         (busy)
	);

	initial begin
		tx_clk = 1'b0;
		forever #HALF_PERIOD tx_clk = ~tx_clk;
	end

	always @(posedge tx_clk) begin
		clk_cycles <= clk_cycles + 1;
	end

	// Watchdog armed once the table sets the limit
	initial begin
		wait (cycle_limit != 0);
		wait (clk_cycles >= cycle_limit);
		$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
		$display("Testbench failed");
		$finish;
	end

	// Inputs change and outputs are read a little after the rising edge
	task automatic next_cycle();
		@(posedge tx_clk);
		#DRIVE_DELAY;
	endtask

	function automatic logic [31:0] reflect32(input logic [31:0] v);
		logic [31:0] r;
		for (int i = 0; i < 32; i++) begin
			r[i] = v[31-i];
		end
		return r;
	endfunction

	// Bit-serial Ethernet CRC with each byte entering LSB first
	function automatic logic [31:0] model_crc32(input logic [7:0] data[$]);
		logic [31:0] poly;
		logic [31:0] c;
		logic        fb;
		poly = reflect32(32'h04C11DB7);
		c    = 32'hFFFFFFFF;
		foreach (data[n]) begin
			for (int b = 0; b < 8; b++) begin
				fb = c[0] ^ data[n][b];
				c  = c >> 1;
				if (fb) begin
					c = c ^ poly;
				end
			end
		end
		return ~c;
	endfunction

	task automatic set_row(input int idx, input string name, input int len,
		input logic [7:0] base, input bit extra);
		row_name[idx]  = name;
		row_len[idx]   = len;
		row_base[idx]  = base;
		row_extra[idx] = extra;
	endtask

	task automatic load_table();
		set_row(0, "min_len", `TX_MIN_LEN, 8'h00, 1'b0);
		set_row(1, "max_len", `TX_MAX_LEN, 8'h10, 1'b0);
		set_row(2, "typical_64", 64, 8'hA0, 1'b0);
		set_row(3, "typical_512", 512, 8'h3C, 1'b0);
		// Bases close to 255 so the pattern wraps
		set_row(4, "wrap_base", 100, 8'hF0, 1'b0);
		set_row(5, "wrap_full", 300, 8'hFF, 1'b0);
		set_row(6, "start_while_busy", 80, 8'h20, 1'b1);
		set_row(7, "random_base", 200, 8'($random(seed)), 1'b0);
	endtask

	task automatic expect_equal(input string test, input string what,
		input int exp_v, input int act_v);
		assert (act_v == exp_v) else begin
			$display("error %s %s: expected %0d actual %0d", test, what, exp_v, act_v);
			row_errors++;
		end
	endtask

	task automatic report_test(input string test, input int nbytes);
		if (row_errors == 0) begin
			tests_passed++;
			$display("%s: ok, %0d bytes on the wire", test, nbytes);
		end else begin
			tests_failed++;
			$display("%s: %0d checks failed", test, row_errors);
		end
	endtask

	task automatic check_idle_after_reset();
		row_errors = 0;
		repeat (5) begin
			next_cycle();
			assert (!gmii_tx_en && !busy) else begin
				$display("reset_idle: DUT became active without a start pulse");
				row_errors++;
			end
			expect_equal("reset_idle", "gmii_txd", 0, int'(gmii_txd));
		end
		report_test("reset_idle", 0);
	endtask

	task automatic send_frame(input int idx);
		logic [7:0]  payload[$];
		logic [7:0]  expected[$];
		logic [7:0]  got[$];
		logic [31:0] fcs;
		int          start_cyc;
		int          first_en;
		int          en_fall;
		int          busy_fall;
		int          bad_idx;
		bit          en_broken;
		bit          late_activity;
		row_errors    = 0;
		first_en      = -1;
		en_fall       = -1;
		busy_fall     = -1;
		bad_idx       = -1;
		en_broken     = 1'b0;
		late_activity = 1'b0;

		// Reference frame of preamble, SFD, pattern and FCS low byte first
		for (int i = 0; i < row_len[idx]; i++) begin
			payload.push_back(row_base[idx] + 8'(i));
		end
		fcs = model_crc32(payload);
		repeat (`TX_PREAMBLE_LEN) expected.push_back(8'h55);
		expected.push_back(8'hD5);
		foreach (payload[i]) begin
			expected.push_back(payload[i]);
		end
		for (int i = 0; i < 4; i++) begin
			expected.push_back(fcs[8*i +: 8]);
		end

		// One-cycle start pulse taken at the next edge
		payload_len  = `TX_LEN_W'(row_len[idx]);
		pattern_base = row_base[idx];
		start        = 1'b1;
		next_cycle();
		start     = 1'b0;
		start_cyc = clk_cycles;
		// A base that changes mid-frame must not reach the payload
		pattern_base = ~row_base[idx];
		expect_equal(row_name[idx], "busy after start", 1, int'(busy));

		while (busy_fall < 0) begin
			next_cycle();
			// Extra pulse in the middle of the preamble
			start = row_extra[idx] && (clk_cycles == start_cyc + 5);
			if (gmii_tx_en) begin
				if (first_en < 0) begin
					first_en = clk_cycles;
				end
				if (en_fall >= 0) begin
					en_broken = 1'b1;
				end
				got.push_back(gmii_txd);
			end else if (first_en >= 0 && en_fall < 0) begin
				en_fall = clk_cycles;
			end
			if (!busy) begin
				busy_fall = clk_cycles;
			end
		end
		start = 1'b0;

		// A second frame would show up here
		for (int t = 0; t < TAIL_CYCLES; t++) begin
			next_cycle();
			if (gmii_tx_en || busy || gmii_txd != 8'h00) begin
				late_activity = 1'b1;
			end
		end

		expect_equal(row_name[idx], "first byte delay", 1, first_en - start_cyc);
		expect_equal(row_name[idx], "tx_en cycles", expected.size(), got.size());
		expect_equal(row_name[idx], "busy low delay",
			`TX_PREAMBLE_LEN + 1 + row_len[idx] + 4 + `TX_IPG_LEN, busy_fall - start_cyc);
		assert (!en_broken) else begin
			$display("%s: gmii_tx_en dropped in the middle of the frame", row_name[idx]);
			row_errors++;
		end
		assert (!late_activity) else begin
			$display("%s: DUT became active again after the frame", row_name[idx]);
			row_errors++;
		end
		// Stop comparing at the first wrong byte
		foreach (got[i]) begin
			if (i < expected.size() && bad_idx < 0) begin
				assert (got[i] == expected[i]) else begin
					$display("error %s byte %0d: expected 0x%02h actual 0x%02h",
						row_name[idx], i, expected[i], got[i]);
					bad_idx = i;
					row_errors++;
				end
			end
		end
		report_test(row_name[idx], got.size());
	endtask

	initial begin
		rst_n        = 1'b0;
		start        = 1'b0;
		payload_len  = '0;
		pattern_base = '0;
		load_table();

		// Each frame needs about payload_len + 29 cycles
		cycle_limit = 100;
		for (int r = 0; r < N_ROWS; r++) begin
			cycle_limit = cycle_limit + row_len[r] + 30;
		end

		repeat (3) next_cycle();
		rst_n = 1'b1;
		check_idle_after_reset();
		for (int r = 0; r < N_ROWS; r++) begin
			send_frame(r);
		end

		$display("Tests passed %0d failed %0d, assertion failures %0d",
			tests_passed, tests_failed, uut.u_assertions.fail_count);
		if (tests_failed == 0 && uut.u_assertions.fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+logic
logic/tx_pkg.sv
logic/frame_sequencer.sv
logic/fcs_crc32.sv
logic/gmii_tx_mux.sv
logic/frame_tx_top.sv
sim/frame_tx_assertions.sv
sim/frame_tx_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = frame_tx_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
